// ==== source/rv_pkg.sv ====
// shared rv64 core definitions; covers only the integer ALU subset, LUI and EBREAK
package rv_pkg;

    parameter int xlen           = 64;
    parameter int reg_addr_width = 5;

    // pass_b carries the LUI immediate straight through
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_t;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_system = 7'b1110011;

    localparam logic [11:0] ebreak_imm = 12'h001;

    // one instruction word, seen as R type or I type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } inst_fmt_u;

endpackage

// ==== source/rv_fetch.sv ====
// fetch stage; expects the instruction word back in the same cycle, no redirect support
`timescale 1ns/1ps

module rv_fetch #(
    parameter logic [rv_pkg::xlen-1:0] RESET_PC = '0
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    fetch_stop_i,
    input  logic [31:0]             inst_i,
    output logic [rv_pkg::xlen-1:0] inst_addr_o,
    output logic                    if_valid_o,
    output logic [rv_pkg::xlen-1:0] if_pc_o,
    output logic [31:0]             if_inst_o
);

    // inst_addr_o is the program counter itself
    always_ff @(posedge clk) begin
        if (reset_i) begin
            inst_addr_o <= RESET_PC;
            if_valid_o  <= 1'b0;
        end else if (fetch_stop_i) begin
            if_valid_o  <= 1'b0;                 // hold pc, drop the word in flight
        end else begin
            inst_addr_o <= inst_addr_o + 'd4;
            if_valid_o  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!fetch_stop_i) begin
            if_pc_o   <= inst_addr_o;
            if_inst_o <= inst_i;
        end
    end

endmodule

// ==== source/rv_regfile.sv ====
// 31 writable registers plus x0; a same-cycle write is not visible to the read ports
`timescale 1ns/1ps

module rv_regfile (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic [rv_pkg::reg_addr_width-1:0] rs1_addr_i,
    input  logic [rv_pkg::reg_addr_width-1:0] rs2_addr_i,
    output logic [rv_pkg::xlen-1:0]           rs1_data_o,
    output logic [rv_pkg::xlen-1:0]           rs2_data_o,
    input  logic                              wen_i,
    input  logic [rv_pkg::reg_addr_width-1:0] waddr_i,
    input  logic [rv_pkg::xlen-1:0]           wdata_i
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int n = 1; n < 32; n++) begin
                regs[n] <= '0;
            end
        end else if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 is not stored
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== source/rv_decode.sv ====
// decode stage; anything outside the ALU subset, LUI and EBREAK counts as illegal
`timescale 1ns/1ps

module rv_decode (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              if_valid_i,
    input  logic [rv_pkg::xlen-1:0]           if_pc_i,
    input  logic [31:0]                       if_inst_i,
    input  logic                              squash_i,
    output logic [rv_pkg::reg_addr_width-1:0] rs1_addr_o,
    output logic [rv_pkg::reg_addr_width-1:0] rs2_addr_o,
    input  logic [rv_pkg::xlen-1:0]           rs1_data_i,
    input  logic [rv_pkg::xlen-1:0]           rs2_data_i,
    input  logic                              ex_fwd_wen_i,
    input  logic [rv_pkg::reg_addr_width-1:0] ex_fwd_rd_i,
    input  logic [rv_pkg::xlen-1:0]           ex_fwd_data_i,
    input  logic                              wb_fwd_wen_i,
    input  logic [rv_pkg::reg_addr_width-1:0] wb_fwd_rd_i,
    input  logic [rv_pkg::xlen-1:0]           wb_fwd_data_i,
    output logic                              ex_valid_o,
    output logic [rv_pkg::xlen-1:0]           ex_pc_o,
    output rv_pkg::alu_op_t                   ex_alu_op_o,
    output logic [rv_pkg::xlen-1:0]           ex_src1_o,
    output logic [rv_pkg::xlen-1:0]           ex_src2_o,
    output logic [rv_pkg::reg_addr_width-1:0] ex_rd_o,
    output logic                              ex_wen_o,
    output logic                              ex_halt_req_o,
    output logic                              ex_illegal_o
);
    import rv_pkg::*;

    inst_fmt_u       fmt;
    alu_op_t         alu_op;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic            wen;
    logic            is_ebreak;
    logic            unknown;

    // execute result is younger, so it wins over writeback
    function automatic logic [xlen-1:0] fwd_value(
        input logic [reg_addr_width-1:0] addr,
        input logic [xlen-1:0]           rf_value
    );
        if (ex_fwd_wen_i && ex_fwd_rd_i != '0 && ex_fwd_rd_i == addr) begin
            return ex_fwd_data_i;
        end else if (wb_fwd_wen_i && wb_fwd_rd_i != '0 && wb_fwd_rd_i == addr) begin
            return wb_fwd_data_i;
        end
        return rf_value;
    endfunction

    // shared funct3 map; alt selects sub or sra
    function automatic alu_op_t funct3_op(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign fmt        = if_inst_i;
    assign rs1_addr_o = fmt.r.rs1;
    assign rs2_addr_o = fmt.r.rs2;
    assign imm_i      = {{(xlen-12){fmt.i.imm12[11]}}, fmt.i.imm12};
    assign imm_u      = {{(xlen-32){if_inst_i[31]}}, if_inst_i[31:12], 12'b0};

    always_comb begin
        alu_op    = alu_add;
        src1      = fwd_value(fmt.r.rs1, rs1_data_i);
        src2      = fwd_value(fmt.r.rs2, rs2_data_i);
        wen       = 1'b0;
        is_ebreak = 1'b0;
        unknown   = 1'b0;
        case (fmt.r.opcode)
            op_reg: begin
                alu_op = funct3_op(fmt.r.funct3, fmt.r.funct7[5]);
                wen    = 1'b1;
            end
            op_imm: begin
                // bit 30 only means sra for funct3 101, never subi
                alu_op = funct3_op(fmt.i.funct3, fmt.i.imm12[10] && fmt.i.funct3 == 3'b101);
                src2   = imm_i;
                wen    = 1'b1;
            end
            op_lui: begin
                alu_op = alu_pass_b;
                src2   = imm_u;
                wen    = 1'b1;
            end
            op_system: begin
                is_ebreak = fmt.i.imm12 == ebreak_imm && fmt.i.funct3 == 3'b000;
                unknown   = !is_ebreak;                  // ecall and csr ops not supported
            end
            default: unknown = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_valid_o    <= 1'b0;
            ex_wen_o      <= 1'b0;
            ex_halt_req_o <= 1'b0;
            ex_illegal_o  <= 1'b0;
        end else begin
            ex_valid_o    <= if_valid_i && !squash_i;
            ex_wen_o      <= wen;
            ex_halt_req_o <= is_ebreak || unknown;
            ex_illegal_o  <= unknown;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc_o     <= if_pc_i;
        ex_alu_op_o <= alu_op;
        ex_src1_o   <= src1;
        ex_src2_o   <= src2;
        ex_rd_o     <= fmt.r.rd;
    end

endmodule

// ==== source/rv_alu.sv ====
// execute stage; a halt instruction never reaches writeback
`timescale 1ns/1ps

module rv_alu (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              ex_valid_i,
    input  logic [rv_pkg::xlen-1:0]           ex_pc_i,
    input  rv_pkg::alu_op_t                   ex_alu_op_i,
    input  logic [rv_pkg::xlen-1:0]           ex_src1_i,
    input  logic [rv_pkg::xlen-1:0]           ex_src2_i,
    input  logic [rv_pkg::reg_addr_width-1:0] ex_rd_i,
    input  logic                              ex_wen_i,
    input  logic                              ex_halt_req_i,
    output logic [rv_pkg::xlen-1:0]           ex_result_o,
    output logic                              wb_valid_o,
    output logic [rv_pkg::xlen-1:0]           wb_pc_o,
    output logic [rv_pkg::reg_addr_width-1:0] wb_rd_o,
    output logic [rv_pkg::xlen-1:0]           wb_data_o,
    output logic                              wb_wen_o
);
    import rv_pkg::*;

    logic [5:0] shamt;

    assign shamt = ex_src2_i[5:0];                  // rv64 shift amount

    always_comb begin
        case (ex_alu_op_i)
            alu_add:  ex_result_o = ex_src1_i + ex_src2_i;
            alu_sub:  ex_result_o = ex_src1_i - ex_src2_i;
            alu_sll:  ex_result_o = ex_src1_i << shamt;
            alu_slt:  ex_result_o = {{(xlen-1){1'b0}}, $signed(ex_src1_i) < $signed(ex_src2_i)};
            alu_sltu: ex_result_o = {{(xlen-1){1'b0}}, ex_src1_i < ex_src2_i};
            alu_xor:  ex_result_o = ex_src1_i ^ ex_src2_i;
            alu_srl:  ex_result_o = ex_src1_i >> shamt;
            alu_sra:  ex_result_o = $signed(ex_src1_i) >>> shamt;
            alu_or:   ex_result_o = ex_src1_i | ex_src2_i;
            alu_and:  ex_result_o = ex_src1_i & ex_src2_i;
            default:  ex_result_o = ex_src2_i;      // lui
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
            wb_wen_o   <= 1'b0;
        end else begin
            wb_valid_o <= ex_valid_i && !ex_halt_req_i;
            wb_wen_o   <= ex_wen_i && !ex_halt_req_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc_o   <= ex_pc_i;
        wb_rd_o   <= ex_rd_i;
        wb_data_o <= ex_result_o;
    end

endmodule

// ==== source/rv_pipe_ctrl.sv ====
// halt controller; once halted only a reset restarts the core
`timescale 1ns/1ps

module rv_pipe_ctrl (
    input  logic clk,
    input  logic reset_i,
    input  logic ex_valid_i,
    input  logic ex_halt_req_i,
    input  logic ex_illegal_i,
    output logic fetch_stop_o,
    output logic squash_decode_o,
    output logic halted_o,
    output logic illegal_o
);

    localparam logic [1:0] st_run    = 2'd0;
    localparam logic [1:0] st_drain  = 2'd1;
    localparam logic [1:0] st_halted = 2'd2;

    logic [1:0] state_q;
    logic       illegal_q;
    logic       halt_now;

    assign halt_now        = state_q == st_run && ex_valid_i && ex_halt_req_i;
    assign fetch_stop_o    = halt_now || state_q != st_run;
    assign squash_decode_o = fetch_stop_o;          // nothing younger than the halt proceeds
    assign halted_o        = state_q != st_run;
    assign illegal_o       = illegal_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= st_run;
            illegal_q <= 1'b0;
        end else begin
            case (state_q)
                st_run: begin
                    if (halt_now) begin
                        state_q   <= st_drain;
                        illegal_q <= ex_illegal_i;  // keep the cause
                    end
                end
                st_drain: state_q <= st_halted;
                default:  state_q <= st_halted;
            endcase
        end
    end

endmodule

// ==== source/rv_perf_counter.sv ====
// cycle and retire counters; both saturate and freeze while halted
`timescale 1ns/1ps

module rv_perf_counter #(
    parameter int COUNT_WIDTH = 32
) (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   halted_i,
    input  logic                   retire_i,
    output logic [COUNT_WIDTH-1:0] cycle_count_o,
    output logic [COUNT_WIDTH-1:0] instret_count_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cycle_count_o   <= '0;
            instret_count_o <= '0;
        end else if (!halted_i) begin
            if (cycle_count_o != '1) begin
                cycle_count_o <= cycle_count_o + 1'b1;
            end
            if (retire_i && instret_count_o != '1) begin
                instret_count_o <= instret_count_o + 1'b1;
            end
        end
    end

endmodule

// ==== source/rv_core_top.sv ====
// rv64 core top; instruction memory must answer combinationally, no data memory
`timescale 1ns/1ps

module rv_core_top #(
    parameter logic [rv_pkg::xlen-1:0] RESET_PC    = '0,
    parameter int                      COUNT_WIDTH = 32
) (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic [31:0]                       inst_i,
    output logic [rv_pkg::xlen-1:0]           inst_addr_o,
    output logic                              wb_valid_o,
    output logic [rv_pkg::xlen-1:0]           wb_pc_o,
    output logic [rv_pkg::reg_addr_width-1:0] wb_rd_o,
    output logic [rv_pkg::xlen-1:0]           wb_data_o,
    output logic                              wb_wen_o,
    output logic                              halted_o,
    output logic                              illegal_o,
    output logic [COUNT_WIDTH-1:0]            cycle_count_o,
    output logic [COUNT_WIDTH-1:0]            instret_count_o
);
    import rv_pkg::*;

    logic                      fetch_stop;
    logic                      squash_decode;
    logic                      if_valid;
    logic [xlen-1:0]           if_pc;
    logic [31:0]               if_inst;
    logic [reg_addr_width-1:0] rs1_addr;
    logic [reg_addr_width-1:0] rs2_addr;
    logic [xlen-1:0]           rs1_data;
    logic [xlen-1:0]           rs2_data;
    logic                      ex_valid;
    logic [xlen-1:0]           ex_pc;
    alu_op_t                   ex_alu_op;
    logic [xlen-1:0]           ex_src1;
    logic [xlen-1:0]           ex_src2;
    logic [reg_addr_width-1:0] ex_rd;
    logic                      ex_wen;
    logic                      ex_halt_req;
    logic                      ex_illegal;
    logic [xlen-1:0]           ex_result;
    logic                      rf_wen;

    assign rf_wen = wb_valid_o && wb_wen_o;         // retiring write

    rv_fetch #(
        .RESET_PC(RESET_PC)
    ) i_fetch (
        .clk          (clk),
        .reset_i      (reset_i),
        .fetch_stop_i (fetch_stop),
        .inst_i       (inst_i),
        .inst_addr_o  (inst_addr_o),
        .if_valid_o   (if_valid),
        .if_pc_o      (if_pc),
        .if_inst_o    (if_inst)
    );

    rv_regfile i_regfile (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wen_i      (rf_wen),
        .waddr_i    (wb_rd_o),
        .wdata_i    (wb_data_o)
    );

    rv_decode i_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .if_valid_i    (if_valid),
        .if_pc_i       (if_pc),
        .if_inst_i     (if_inst),
        .squash_i      (squash_decode),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .ex_fwd_wen_i  (ex_valid && ex_wen),        // execute result bypass
        .ex_fwd_rd_i   (ex_rd),
        .ex_fwd_data_i (ex_result),
        .wb_fwd_wen_i  (rf_wen),                    // writeback bypass
        .wb_fwd_rd_i   (wb_rd_o),
        .wb_fwd_data_i (wb_data_o),
        .ex_valid_o    (ex_valid),
        .ex_pc_o       (ex_pc),
        .ex_alu_op_o   (ex_alu_op),
        .ex_src1_o     (ex_src1),
        .ex_src2_o     (ex_src2),
        .ex_rd_o       (ex_rd),
        .ex_wen_o      (ex_wen),
        .ex_halt_req_o (ex_halt_req),
        .ex_illegal_o  (ex_illegal)
    );

    rv_alu i_alu (
        .clk           (clk),
        .reset_i       (reset_i),
        .ex_valid_i    (ex_valid),
        .ex_pc_i       (ex_pc),
        .ex_alu_op_i   (ex_alu_op),
        .ex_src1_i     (ex_src1),
        .ex_src2_i     (ex_src2),
        .ex_rd_i       (ex_rd),
        .ex_wen_i      (ex_wen),
        .ex_halt_req_i (ex_halt_req),
        .ex_result_o   (ex_result),
        .wb_valid_o    (wb_valid_o),
        .wb_pc_o       (wb_pc_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .wb_wen_o      (wb_wen_o)
    );

    rv_pipe_ctrl i_pipe_ctrl (
        .clk             (clk),
        .reset_i         (reset_i),
        .ex_valid_i      (ex_valid),
        .ex_halt_req_i   (ex_halt_req),
        .ex_illegal_i    (ex_illegal),
        .fetch_stop_o    (fetch_stop),
        .squash_decode_o (squash_decode),
        .halted_o        (halted_o),
        .illegal_o       (illegal_o)
    );

    rv_perf_counter #(
        .COUNT_WIDTH(COUNT_WIDTH)
    ) i_perf_counter (
        .clk             (clk),
        .reset_i         (reset_i),
        .halted_i        (halted_o),
        .retire_i        (wb_valid_o),
        .cycle_count_o   (cycle_count_o),
        .instret_count_o (instret_count_o)
    );

endmodule

// ==== test/rv_ref_model.svh ====
// rv64 ALU subset model; include inside the testbench module, only 0x00100073 counts as EBREAK
localparam logic [31:0] ebreak_word = 32'h0010_0073;
localparam int          cls_retire  = 0;
localparam int          cls_ebreak  = 1;
localparam int          cls_illegal = 2;

logic [63:0] model_regs [32];

function automatic logic [31:0] enc_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] funct3,
                                      input logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] funct3, input logic [4:0] rd);
    return {imm, rs1, funct3, rd, 7'b0010011};
endfunction

function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
endfunction

// retires, halts cleanly or halts as illegal
function automatic int ref_class(input logic [31:0] inst);
    case (inst[6:0])
        7'b0110011, 7'b0010011, 7'b0110111: return cls_retire;
        default: return (inst == ebreak_word) ? cls_ebreak : cls_illegal;
    endcase
endfunction

function automatic void model_clear();
    for (int n = 0; n < 32; n++) begin
        model_regs[n] = '0;
    end
endfunction

// executes one retiring instruction on the model registers
function automatic void ref_exec(input logic [31:0] inst, output logic [4:0] rd,
                                 output logic [63:0] data, output logic wen);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] sign_bit;
    logic [5:0]  sh;
    logic        is_reg;
    sign_bit = 64'h8000_0000_0000_0000;
    is_reg   = inst[6:0] == 7'b0110011;
    a        = model_regs[inst[19:15]];
    b        = is_reg ? model_regs[inst[24:20]] : {{52{inst[31]}}, inst[31:20]};
    sh       = b[5:0];                              // rv64 shifts use six bits
    rd       = inst[11:7];
    wen      = 1'b1;
    if (inst[6:0] == 7'b0110111) begin
        data = {{32{inst[31]}}, inst[31:12], 12'h000};
    end else begin
        case (inst[14:12])
            3'd0: data = (is_reg && inst[30]) ? a - b : a + b;
            3'd1: data = a << sh;
            3'd2: data = {63'd0, (a ^ sign_bit) < (b ^ sign_bit)};  // signed via bias
            3'd3: data = {63'd0, a < b};
            3'd4: data = a ^ b;
            3'd5: begin
                data = a >> sh;
                if (inst[30] && a[63]) begin
                    data = data | ~(64'hFFFF_FFFF_FFFF_FFFF >> sh);     // fill sign bits
                end
            end
            3'd6: data = a | b;
            default: data = a & b;
        endcase
    end
    if (rd != 5'd0) begin
        model_regs[rd] = data;                      // x0 stays zero
    end
endfunction

// ==== test/tb_rv_core.sv ====
// testbench for rv_core_top with default parameters; imem is 64 words, EBREAK beyond the program
`timescale 1ns/1ps

module tb_rv_core;

    localparam logic [63:0] reset_pc        = 64'h0;
    localparam int          directed_len    = 25;
    localparam int          deps_len        = 16;
    localparam int          random_len      = 40;
    localparam int          illegal_len     = 5;
    localparam int          total_len       = directed_len + 3 * deps_len + 3 * random_len
                                              + illegal_len;     // deps runs three times
    localparam int          watchdog_cycles = 8 * total_len + 100;

    logic        clk;
    logic        reset_i;
    logic [31:0] inst_i;
    logic [63:0] inst_addr_o;
    logic        wb_valid_o;
    logic [63:0] wb_pc_o;
    logic [4:0]  wb_rd_o;
    logic [63:0] wb_data_o;
    logic        wb_wen_o;
    logic        halted_o;
    logic        illegal_o;
    logic [31:0] cycle_count_o;
    logic [31:0] instret_count_o;

    logic [31:0] imem [64];
    int          prog_len;
    int          exp_idx;
    int          retired;
    int          checks;
    int          errors;
    logic [31:0] lfsr_state = 32'd95572;

    `include "rv_ref_model.svh"

    rv_core_top i_dut (
        .clk             (clk),
        .reset_i         (reset_i),
        .inst_i          (inst_i),
        .inst_addr_o     (inst_addr_o),
        .wb_valid_o      (wb_valid_o),
        .wb_pc_o         (wb_pc_o),
        .wb_rd_o         (wb_rd_o),
        .wb_data_o       (wb_data_o),
        .wb_wen_o        (wb_wen_o),
        .halted_o        (halted_o),
        .illegal_o       (illegal_o),
        .cycle_count_o   (cycle_count_o),
        .instret_count_o (instret_count_o)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] imem_read(input logic [63:0] addr);
        logic [63:0] idx;
        idx = (addr - reset_pc) >> 2;
        if (^addr === 1'bx || idx >= 64'(prog_len)) begin
            return ebreak_word;                     // past the program end
        end
        return imem[idx[5:0]];
    endfunction

    // instruction memory answers within the cycle, updated mid-cycle
    always @(negedge clk) begin
        inst_i <= imem_read(inst_addr_o);
    end

    function automatic logic lfsr_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr_bit()};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        checks++;
        assert (ok === 1'b1) else begin
            errors++;
            $display("ERROR: %s", what);
        end
    endtask

    task automatic check_retire();
        logic [31:0] inst;
        logic [4:0]  rd;
        logic [63:0] data;
        logic        wen;
        logic [63:0] pc;
        pc   = reset_pc + 64'(exp_idx) * 64'd4;
        inst = imem_read(pc);
        if (ref_class(inst) != cls_retire) begin
            check_true(1'b0, "an instruction retired after the halt instruction");
        end else begin
            ref_exec(inst, rd, data, wen);
            check_value("wb_pc_o", wb_pc_o, pc);
            check_value("wb_rd_o", 64'(wb_rd_o), 64'(rd));
            check_value("wb_data_o", wb_data_o, data);
            check_value("wb_wen_o", 64'(wb_wen_o), 64'(wen));
            exp_idx++;
            retired++;
        end
    endtask

    // retirement checker, outputs read before the edge updates them
    always @(posedge clk) begin
        if (reset_i === 1'b0 && wb_valid_o === 1'b1) begin
            check_retire();
        end
    end

    task automatic emit(input logic [31:0] inst);
        imem[prog_len] = inst;
        prog_len++;
    endtask

    task automatic clear_state();
        model_clear();
        exp_idx = 0;
        retired = 0;
    endtask

    task automatic begin_test();
        @(negedge clk);
        reset_i  = 1'b1;
        clear_state();
        prog_len = 0;
    endtask

    task automatic release_reset();
        repeat (4) @(negedge clk);
        reset_i = 1'b0;
    endtask

    task automatic check_halt();
        logic [31:0] frozen;
        int          halt_idx;
        int          cls;
        halt_idx = 0;
        while (ref_class(imem_read(reset_pc + 64'(halt_idx) * 64'd4)) == cls_retire) begin
            halt_idx++;
        end
        cls    = ref_class(imem_read(reset_pc + 64'(halt_idx) * 64'd4));
        frozen = cycle_count_o;
        repeat (6) @(negedge clk);                  // room for a stray retirement
        check_value("halted_o", 64'(halted_o), 64'd1);
        check_value("illegal_o", 64'(illegal_o), (cls == cls_illegal) ? 64'd1 : 64'd0);
        check_value("cycle_count_o", 64'(cycle_count_o), 64'(frozen));
        check_value("instret_count_o", 64'(instret_count_o), 64'(retired));
        check_value("retirements", 64'(retired), 64'(halt_idx));
        check_true(cycle_count_o >= instret_count_o + 32'd3,
                   "cycle count is below the retired count plus three");
    endtask

    task automatic run_program();
        release_reset();
        while (halted_o !== 1'b1) @(negedge clk);   // watchdog bounds this
        check_halt();
    endtask

    task automatic build_directed();
        emit(enc_lui(20'h80000, 5'd1));
        emit(enc_i(12'hffb, 5'd0, 3'd0, 5'd2));     // x2 = -5
        emit(enc_i(12'h007, 5'd0, 3'd0, 5'd3));
        emit(enc_i(12'h03f, 5'd0, 3'd0, 5'd7));     // x7 = 63
        emit(enc_r(7'h00, 5'd3, 5'd1, 3'd0, 5'd4));
        emit(enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd5));
        emit(enc_r(7'h00, 5'd7, 5'd3, 3'd1, 5'd6));
        emit(enc_r(7'h00, 5'd3, 5'd2, 3'd2, 5'd8)); // signed -5 < 7
        emit(enc_r(7'h00, 5'd3, 5'd2, 3'd3, 5'd9)); // unsigned, not less
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd10));
        emit(enc_r(7'h00, 5'd7, 5'd1, 3'd5, 5'd11));
        emit(enc_r(7'h20, 5'd7, 5'd1, 3'd5, 5'd12));
        emit(enc_r(7'h00, 5'd3, 5'd2, 3'd6, 5'd13));
        emit(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd14));
        emit(enc_i(12'hffc, 5'd2, 3'd2, 5'd15));
        emit(enc_i(12'hfff, 5'd3, 3'd3, 5'd16));
        emit(enc_i(12'hfff, 5'd1, 3'd4, 5'd17));
        emit(enc_i(12'h03f, 5'd3, 3'd1, 5'd18));
        emit(enc_i(12'h03f, 5'd1, 3'd5, 5'd19));
        emit(enc_i(12'h43f, 5'd2, 3'd5, 5'd20));    // srai by 63
        emit(enc_i(12'h7ff, 5'd2, 3'd6, 5'd21));
        emit(enc_i(12'hff0, 5'd1, 3'd7, 5'd22));
        emit(enc_r(7'h20, 5'd3, 5'd2, 3'd5, 5'd23));
        emit(enc_lui(20'h7ffff, 5'd24));
        emit(ebreak_word);
    endtask

    // each instruction leans on the one or two before it
    task automatic build_deps();
        emit(enc_r(7'h00, 5'd4, 5'd3, 3'd6, 5'd11)); // reads registers right after reset
        emit(enc_i(12'h001, 5'd0, 3'd0, 5'd1));
        emit(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
        emit(enc_r(7'h00, 5'd1, 5'd2, 3'd0, 5'd3));
        emit(enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd4));
        emit(enc_r(7'h00, 5'd3, 5'd4, 3'd4, 5'd5));
        emit(enc_i(12'h063, 5'd5, 3'd0, 5'd0));     // write to x0
        emit(enc_r(7'h00, 5'd5, 5'd0, 3'd0, 5'd6));
        emit(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd7));
        emit(enc_i(12'h004, 5'd6, 3'd1, 5'd1));
        emit(enc_r(7'h20, 5'd6, 5'd1, 3'd5, 5'd2));
        emit(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd1));
        emit(enc_r(7'h00, 5'd1, 5'd0, 3'd3, 5'd3));
        emit(ebreak_word);
        emit(enc_i(12'h001, 5'd0, 3'd0, 5'd9));     // must never retire
        emit(enc_i(12'h002, 5'd0, 3'd0, 5'd10));
    endtask

    task automatic build_random(input int n);
        logic [1:0]  kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic        alt;
        for (int k = 0; k < n - 1; k++) begin
            kind = 2'(rand_bits(2));
            rd   = 5'(rand_bits(3));                // x0 to x7 keeps chains dense
            rs1  = 5'(rand_bits(3));
            f3   = 3'(rand_bits(3));
            case (kind)
                2'd0: begin
                    rs2 = 5'(rand_bits(3));
                    alt = (f3 == 3'd0 || f3 == 3'd5) && lfsr_bit();
                    emit(enc_r(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd));
                end
                2'd3: emit(enc_lui(20'(rand_bits(20)), rd));
                default: begin
                    imm = 12'(rand_bits(12));
                    if (f3 == 3'd1) begin
                        imm[11:6] = 6'd0;
                    end else if (f3 == 3'd5) begin
                        imm[11:6] = {1'b0, lfsr_bit(), 4'd0};  // srli or srai
                    end
                    emit(enc_i(imm, rs1, f3, rd));
                end
            endcase
        end
        emit(ebreak_word);
    endtask

    task automatic build_illegal();
        emit(enc_i(12'h003, 5'd0, 3'd0, 5'd1));
        emit(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
        emit(32'h0000_3083);                        // ld, not supported
        emit(enc_i(12'h001, 5'd0, 3'd0, 5'd3));
        emit(enc_i(12'h002, 5'd0, 3'd0, 5'd4));
    endtask

    task automatic report_and_finish();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        errors++;
        $display("ERROR: halted_o did not rise within %0d cycles", watchdog_cycles);
        report_and_finish();
    end

    initial begin
        clk      = 1'b0;
        reset_i  = 1'b1;
        inst_i   = 32'h0000_0013;                   // nop until fetch starts
        prog_len = 0;
        checks   = 0;
        errors   = 0;
        clear_state();
        begin_test();
        build_directed();
        run_program();
        begin_test();
        build_deps();
        run_program();
        repeat (3) begin
            begin_test();
            build_random(random_len);
            run_program();
        end
        begin_test();
        build_illegal();
        run_program();
        // reset after the illegal halt, then again in mid-run
        begin_test();
        build_deps();
        release_reset();
        check_value("halted_o", 64'(halted_o), 64'd0);
        check_value("illegal_o", 64'(illegal_o), 64'd0);
        check_value("inst_addr_o", inst_addr_o, reset_pc);
        check_value("wb_valid_o", 64'(wb_valid_o), 64'd0);
        while (retired < 6) @(negedge clk);
        reset_i = 1'b1;
        clear_state();
        run_program();
        report_and_finish();
    end

endmodule

// ==== compile.f ====
+incdir+test
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_regfile.sv
source/rv_decode.sv
source/rv_alu.sv
source/rv_pipe_ctrl.sv
source/rv_perf_counter.sv
source/rv_core_top.sv
test/tb_rv_core.sv
